/* logic/cromRegister.sv */
//////////////////////////////
// Microword register, one load per clock enable
// Clears to all zeros, so the first address is 0
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ks10Seq_defs.svh"

module cromRegister
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    clkEn,
   input  logic [`CROM_WIDTH-1:0]  crom,
   output ks10SeqPkg::cromWord_t   word
);

   //////////////////////////////
   // Register
   //////////////////////////////

   // Raw word as it came from the store
   logic [`CROM_WIDTH-1:0] cromReg;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cromReg <= '0;
      end
      else if (clkEn)
      begin
         // One microinstruction per enabled cycle
         cromReg <= crom;
      end
   end

   //////////////////////////////
   // Decode
   //////////////////////////////

   // Fields line up with the struct, MSB first
   assign word = ks10SeqPkg::cromWord_t'(cromReg);

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Store must answer with clean data
   // Catches an address that runs off the model
   wordKnown : assert property (
      @(posedge clk) disable iff (rst)
      !$isunknown(word)
   )
   else $error("cromRegister: word has unknown bits");

   // No enable, no new microinstruction
   wordHolds : assert property (
      @(posedge clk) disable iff (rst)
      !clkEn |=> $stable(word)
   )
   else $error("cromRegister: word changed without clkEn");

endmodule

`default_nettype wire

/* logic/ks10SeqPkg.sv */
//////////////////////////////
// Microword and flag types for the sequencer slice
// Word layout is MSB first, jump field on top
//////////////////////////////
`default_nettype none

`include "ks10Seq_defs.svh"

package ks10SeqPkg;

   //////////////////////////////
   // Decoded microword
   //////////////////////////////

   // 12 + 1 + 1 + 3 = CROM_WIDTH bits
   typedef struct packed {
      logic [`CRA_WIDTH-1:0]      j;
      logic                       dispNi;
      logic                       specEn;
      logic [`SPEC_SEL_WIDTH-1:0] specSel;
   } cromWord_t;

   //////////////////////////////
   // Dispatch inputs
   //////////////////////////////

   // Plain levels, no handshake
   typedef struct packed {
      logic trap1;
      logic trap2;
      logic aprTrapEn;
      logic cslTrapEn;
      logic cpuRun;
      logic memoryCycle;
   } niFlags_t;

   // Names for the NICOND low bits
   typedef enum logic [2:0] {
      niBoth  = `TRAP_CODE_BOTH,
      niTrap2 = `TRAP_CODE_TRAP2,
      niTrap1 = `TRAP_CODE_TRAP1,
      niHalt  = `TRAP_CODE_HALT,
      niNone  = `TRAP_CODE_NONE
   } niLow_t;

endpackage

`default_nettype wire

/* logic/ks10Seq_defs.svh */
//////////////////////////////
// Widths and microcode field values for the sequencer slice
// Field values follow the KS-10 CRAM special-function encoding
//////////////////////////////
`ifndef KS10SEQ_DEFS_SVH
`define KS10SEQ_DEFS_SVH

// Raw control-store word and address widths
`define CROM_WIDTH 17
`define CRA_WIDTH 12

// Dispatch code and special-select widths
`define DISP_WIDTH 4
`define SPEC_SEL_WIDTH 3

// Special function that loads the trap cycle
`define SPEC_LOADNICOND 3'd5

// NICOND low three bits
`define TRAP_CODE_BOTH 3'd1
`define TRAP_CODE_TRAP2 3'd2
`define TRAP_CODE_TRAP1 3'd3
`define TRAP_CODE_HALT 3'd5
`define TRAP_CODE_NONE 3'd7

`endif

/* logic/microSequencer.sv */
//////////////////////////////
// Sequencer top, instances and wires only
// Control store sits outside, answers cromAddr at once
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ks10Seq_defs.svh"

module microSequencer
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    clkEn,
   input  logic [`CROM_WIDTH-1:0]  crom,
   input  ks10SeqPkg::niFlags_t    flags,
   output logic [`CRA_WIDTH-1:0]   cromAddr,
   output logic [`DISP_WIDTH-1:0]  dispNi,
   output logic                    trapCycle
);

   // Current microinstruction
   ks10SeqPkg::cromWord_t word;

   //////////////////////////////
   // Microword register
   //////////////////////////////

   cromRegister i_cromRegister
   (
      .clk   (clk),
      .rst   (rst),
      .clkEn (clkEn),
      .crom  (crom),
      .word  (word)
   );

   //////////////////////////////
   // Dispatch and trap
   //////////////////////////////

   niDispatch i_niDispatch
   (
      .clk       (clk),
      .rst       (rst),
      .clkEn     (clkEn),
      .word      (word),
      .flags     (flags),
      .dispNi    (dispNi),
      .trapCycle (trapCycle)
   );

   // Back out to the store
   nextAddress i_nextAddress
   (
      .word     (word),
      .dispNi   (dispNi),
      .cromAddr (cromAddr)
   );

endmodule

`default_nettype wire

/* logic/nextAddress.sv */
//////////////////////////////
// Next control-store address
// Only the low four bits take the dispatch
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ks10Seq_defs.svh"

module nextAddress
(
   input  ks10SeqPkg::cromWord_t   word,
   input  logic [`DISP_WIDTH-1:0]  dispNi,
   output logic [`CRA_WIDTH-1:0]   cromAddr
);

   //////////////////////////////
   // Address mux
   //////////////////////////////

   // Dispatch bits after the select
   logic [`DISP_WIDTH-1:0] dispBits;

   always_comb
   begin
      // Nothing ORed in unless the word asks
      dispBits = word.dispNi ? dispNi : '0;

      // Jump field, low nibble widened by the dispatch
      cromAddr = {word.j[`CRA_WIDTH-1:`DISP_WIDTH],
                  word.j[`DISP_WIDTH-1:0] | dispBits};

      // Upper page never moves
      assert (cromAddr[`CRA_WIDTH-1:`DISP_WIDTH] == word.j[`CRA_WIDTH-1:`DISP_WIDTH])
      else $error("nextAddress: high address bits differ from jump field");
   end

endmodule

`default_nettype wire

/* logic/niDispatch.sv */
//////////////////////////////
// NICOND 16-way dispatch and trap-cycle flag
// Dispatch is combinational from the flags only
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ks10Seq_defs.svh"

module niDispatch
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    clkEn,
   input  ks10SeqPkg::cromWord_t   word,
   input  ks10SeqPkg::niFlags_t    flags,
   output logic [`DISP_WIDTH-1:0]  dispNi,
   output logic                    trapCycle
);

   //////////////////////////////
   // Microcode decode
   //////////////////////////////

   // Special function asks for the NICOND load
   logic specLoadNiCond;
   assign specLoadNiCond = word.specEn && (word.specSel == `SPEC_LOADNICOND);

   // Traps count only with both enables
   logic trapEn;
   assign trapEn = flags.cslTrapEn & flags.aprTrapEn;

   // Trap waiting to be taken
   logic trapPending;
   assign trapPending = trapEn & (flags.trap1 | flags.trap2);

   //////////////////////////////
   // NICOND dispatch
   //////////////////////////////

   ks10SeqPkg::niLow_t lowCode;

   always_comb
   begin
      // First match wins
      if (trapEn && flags.trap1 && flags.trap2)
         lowCode = ks10SeqPkg::niBoth;
      else if (trapEn && flags.trap2)
         lowCode = ks10SeqPkg::niTrap2;
      else if (trapEn && flags.trap1)
         lowCode = ks10SeqPkg::niTrap1;
      else if (trapEn && !flags.cpuRun)
         lowCode = ks10SeqPkg::niHalt;
      else
         lowCode = ks10SeqPkg::niNone;
   end

   // Bit 3 flags a memory cycle in flight
   assign dispNi = {flags.memoryCycle, lowCode};

   //////////////////////////////
   // Trap cycle
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trapCycle <= 1'b0;
      end
      else if (clkEn && specLoadNiCond)
      begin
         // Loads both ways, holds otherwise
         trapCycle <= trapPending;
      end
   end

   // Rise only from an enabled load with a trap waiting
   trapRise : assert property (
      @(posedge clk) disable iff (rst)
      $rose(trapCycle) |-> $past(clkEn && specLoadNiCond && trapPending)
   )
   else $error("niDispatch: trapCycle rose without a pending trap load");

endmodule

`default_nettype wire

/* project.f */
+incdir+logic
logic/ks10SeqPkg.sv
logic/cromRegister.sv
logic/niDispatch.sv
logic/nextAddress.sv
logic/microSequencer.sv
verif/tb_microSequencer.sv

/* run.sh */
#!/bin/sh
# Build and run the microsequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f project.f --top-module tb_microSequencer -o simv || exit 1
simOut=$(./obj_dir/simv 2>&1) || { echo "$simOut"; exit 1; }
echo "$simOut"
echo "$simOut" | grep -q "TESTBENCH PASSED" && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

/* verif/tb_microSequencer.sv */
//////////////////////////////
// Testbench for the sequencer slice, random store and flags
// Store model answers cromAddr combinationally
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ks10Seq_defs.svh"

module tb_microSequencer;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 2;
   localparam int NUM_CYCLES   = 2000;
   localparam int MARGIN       = 100;

   // DUT ports
   logic                           clk = 1'b0;
   logic                           rst;
   logic                           clkEn;
   logic [`CROM_WIDTH-1:0]         crom;
   ks10SeqPkg::niFlags_t           flags;
   logic [`CRA_WIDTH-1:0]          cromAddr;
   logic [`DISP_WIDTH-1:0]         dispNi;
   logic                           trapCycle;

   // Control store, 4096 words
   ks10SeqPkg::cromWord_t cromMem [0:4095];

   // Reference state
   ks10SeqPkg::cromWord_t refWord;
   logic                  refTrap;
   logic                  enabledSeen;
   logic [`DISP_WIDTH-1:0] expDisp;
   logic [`CRA_WIDTH-1:0]  expAddr;

   // Previous-edge copies for the hold checks
   logic                  prevEn;
   ks10SeqPkg::niFlags_t  prevFlags;
   logic [`CRA_WIDTH-1:0] prevAddr;
   logic                  prevTrap;

   int seed;
   int errorCount = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   microSequencer i_microSequencer
   (
      .clk       (clk),
      .rst       (rst),
      .clkEn     (clkEn),
      .crom      (crom),
      .flags     (flags),
      .cromAddr  (cromAddr),
      .dispNi    (dispNi),
      .trapCycle (trapCycle)
   );

   // Store read, no latency
   assign crom = cromMem[cromAddr];

   //////////////////////////////
   // Reference rules
   //////////////////////////////

   // NICOND priority, bit 3 is the memory cycle
   function automatic logic [3:0] expectDisp(input ks10SeqPkg::niFlags_t f);
      logic [2:0] low;
      if (f.cslTrapEn && f.aprTrapEn)
      begin
         if (f.trap1 && f.trap2)
            low = `TRAP_CODE_BOTH;
         else if (f.trap2)
            low = `TRAP_CODE_TRAP2;
         else if (f.trap1)
            low = `TRAP_CODE_TRAP1;
         else if (!f.cpuRun)
            low = `TRAP_CODE_HALT;
         else
            low = `TRAP_CODE_NONE;
      end
      else
      begin
         low = `TRAP_CODE_NONE;
      end
      return {f.memoryCycle, low};
   endfunction

   // Jump field, dispatch ORed into low nibble on request
   function automatic logic [11:0] expectAddr(input ks10SeqPkg::cromWord_t w,
                                              input logic [3:0] disp);
      logic [11:0] addr;
      addr = w.j;
      if (w.dispNi)
         addr[3:0] = w.j[3:0] | disp;
      return addr;
   endfunction

   // Trap taken only with both enables
   function automatic logic trapRule(input ks10SeqPkg::niFlags_t f);
      return f.cslTrapEn && f.aprTrapEn && (f.trap1 || f.trap2);
   endfunction

   assign expDisp = expectDisp(flags);
   assign expAddr = expectAddr(refWord, expDisp);

   // Own copy of the word register and trap flag
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         refWord     <= '0;
         refTrap     <= 1'b0;
         enabledSeen <= 1'b0;
      end
      else if (clkEn)
      begin
         enabledSeen <= 1'b1;
         refWord     <= cromMem[expAddr];
         if (refWord.specEn && refWord.specSel == `SPEC_LOADNICOND)
            refTrap <= trapRule(flags);
      end
   end

   always_ff @(posedge clk)
   begin
      prevEn    <= clkEn;
      prevFlags <= flags;
      prevAddr  <= cromAddr;
      prevTrap  <= trapCycle;
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Reset state until the first enabled edge
   resetAddr : assert property (@(posedge clk) disable iff (rst)
      !enabledSeen |-> cromAddr == 12'd0)
   else
   begin
      errorCount = errorCount + 1;
      $display("[ERROR] t=%0t cromAddr expected %h actual %h",
               $time, 12'd0, $sampled(cromAddr));
   end

   resetTrap : assert property (@(posedge clk) disable iff (rst)
      !enabledSeen |-> trapCycle == 1'b0)
   else
   begin
      errorCount = errorCount + 1;
      $display("[ERROR] t=%0t trapCycle expected %b actual %b",
               $time, 1'b0, $sampled(trapCycle));
   end

   dispCheck : assert property (@(posedge clk) disable iff (rst) dispNi == expDisp)
   else
   begin
      errorCount = errorCount + 1;
      $display("[ERROR] t=%0t dispNi expected %h actual %h",
               $time, $sampled(expDisp), $sampled(dispNi));
   end

   addrCheck : assert property (@(posedge clk) disable iff (rst) cromAddr == expAddr)
   else
   begin
      errorCount = errorCount + 1;
      $display("[ERROR] t=%0t cromAddr expected %h actual %h",
               $time, $sampled(expAddr), $sampled(cromAddr));
   end

   trapCheck : assert property (@(posedge clk) disable iff (rst) trapCycle == refTrap)
   else
   begin
      errorCount = errorCount + 1;
      $display("[ERROR] t=%0t trapCycle expected %b actual %b",
               $time, $sampled(refTrap), $sampled(trapCycle));
   end

   // Idle edge with steady flags leaves the address alone
   holdAddr : assert property (@(posedge clk) disable iff (rst)
      (!prevEn && flags == prevFlags) |-> cromAddr == prevAddr)
   else
   begin
      errorCount = errorCount + 1;
      $display("[ERROR] t=%0t cromAddr expected %h actual %h",
               $time, $sampled(prevAddr), $sampled(cromAddr));
   end

   holdTrap : assert property (@(posedge clk) disable iff (rst)
      !prevEn |-> trapCycle == prevTrap)
   else
   begin
      errorCount = errorCount + 1;
      $display("[ERROR] t=%0t trapCycle expected %b actual %b",
               $time, $sampled(prevTrap), $sampled(trapCycle));
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   // Random words, some forced to NI dispatch and load NICOND
   task automatic fillStore();
      logic [31:0]           rnd;
      logic [12:0]           addr;
      ks10SeqPkg::cromWord_t w;
      for (addr = 13'd0; addr < 13'd4096; addr = addr + 13'd1)
      begin
         rnd = $random(seed);
         w = ks10SeqPkg::cromWord_t'(rnd[16:0]);
         if (addr[2:0] == 3'd3)
         begin
            w.specEn  = 1'b1;
            w.specSel = `SPEC_LOADNICOND;
         end
         if (addr[1:0] == 2'd1)
            w.dispNi = 1'b1;
         cromMem[addr[11:0]] = w;
      end
   endtask

   initial
   begin
      logic [31:0] rnd;
      seed  = 46;
      rst   = 1'b1;
      clkEn = 1'b0;
      flags = '0;
      fillStore();
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      // One idle edge first, so the reset state gets checked
      for (int i = 0; i < NUM_CYCLES; i++)
      begin
         @(negedge clk);
         rnd   = $random(seed);
         flags = ks10SeqPkg::niFlags_t'(rnd[5:0]);
         // Enable low about a quarter of the time
         clkEn = (rnd[9:8] != 2'b00);
      end
      @(negedge clk);
      clkEn = 1'b0;
      repeat (2) @(negedge clk);
      $display("Run complete, %0d errors", errorCount);
      if (errorCount == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   // Watchdog, full run plus margin
   initial
   begin
      #((NUM_CYCLES + RESET_CYCLES + MARGIN) * CLK_PERIOD);
      $display("Watchdog expired, the run did not finish in time");
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire
